// File: common/safe_defs.svh
// Fabric-wide constants shared by RTL and testbench.
// Voting and pairing assume exactly three harts; SAFE_NHARTS is not free to change.
// SAFE_LOCKSTEP_DELAY must be at least 1.
`ifndef SAFE_DEFS_SVH
`define SAFE_DEFS_SVH

// Hart count, fixed by the TMR voter
`define SAFE_NHARTS 3

// Memory bus widths
`define SAFE_ADDR_W 32
`define SAFE_DATA_W 32

// Cycles the DMR partner trails the master
`define SAFE_LOCKSTEP_DELAY 2

// RISC-V WFI encoding, fed to the parked hart
`define SAFE_WFI_INSN 32'h1050_0073

`endif

// File: common/safe_mode_pkg.sv
// Operating mode and hart index types.
// Index values at or above SAFE_NHARTS are illegal and never produced by the fabric.
`include "safe_defs.svh"

package safe_mode_pkg;

  // Fabric operating modes
  typedef enum logic [1:0] {
    MODE_INDEP = 2'd0,
    MODE_TMR   = 2'd1,
    MODE_DMR   = 2'd2
  } fabric_mode_e;

  // Hart index, 0 to SAFE_NHARTS-1
  typedef logic [$clog2(`SAFE_NHARTS)-1:0] hart_idx_t;

endpackage

// File: common/safe_bus_pkg.sv
// Memory bus field types.
// The opcode is the bus write-enable bit.
`include "safe_defs.svh"

package safe_bus_pkg;

  typedef logic [`SAFE_ADDR_W-1:0] addr_t;
  typedef logic [`SAFE_DATA_W-1:0] data_t;

  // Write enable of the bus
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

endpackage

// File: verilog/safe_mode_fsm.sv
// Commits requested mode and master only in a cycle where every hart sleeps.
// Illegal mode or master requests are ignored and the old value holds.
`timescale 1ns/1ps
`include "safe_defs.svh"

module safe_mode_fsm
  import safe_mode_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  fabric_mode_e            mode_req_i,
  input  hart_idx_t               master_req_i,
  input  logic [`SAFE_NHARTS-1:0] sleep_i,
  output fabric_mode_e            mode_o,
  output hart_idx_t               master_o
);

  fabric_mode_e state_q;
  fabric_mode_e state_d;
  hart_idx_t    master_q;
  hart_idx_t    master_d;
  logic         all_sleep;

  // Roles may only change between instructions
  assign all_sleep = &sleep_i;

  always_comb begin
    state_d  = state_q;
    master_d = master_q;
    if (all_sleep) begin
      case (mode_req_i)
        MODE_INDEP: state_d = MODE_INDEP;
        MODE_TMR:   state_d = MODE_TMR;
        MODE_DMR:   state_d = MODE_DMR;
        default:    state_d = state_q;
      endcase
      if (master_req_i < hart_idx_t'(`SAFE_NHARTS)) begin
        master_d = master_req_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= MODE_INDEP;
      master_q <= '0;
    end else begin
      state_q  <= state_d;
      master_q <= master_d;
    end
  end

  assign mode_o   = state_q;
  assign master_o = master_q;

endmodule

// File: lockstep/lockstep_fill_counter.sv
// Flags when the lockstep delay line holds history from the current DMR session.
// Clears as soon as the fabric leaves DMR.
`timescale 1ns/1ps
`include "safe_defs.svh"

module lockstep_fill_counter
  import safe_mode_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  fabric_mode_e mode_i,
  output logic         fill_done_o
);

  localparam int unsigned FILL_CNT = `SAFE_LOCKSTEP_DELAY;
  localparam int unsigned CNT_W    = $clog2(FILL_CNT + 1);

  logic [CNT_W-1:0] cnt_q;

  // Saturates at the delay depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (mode_i != MODE_DMR) begin
      cnt_q <= '0;
    end else if (cnt_q != CNT_W'(FILL_CNT)) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign fill_done_o = (cnt_q == CNT_W'(FILL_CNT));

endmodule

// File: lockstep/lockstep_delay_line.sv
// Delays the master's request and response by SAFE_LOCKSTEP_DELAY cycles.
// Stages only advance while shift_i is high; output is stale until refilled.
`timescale 1ns/1ps
`include "safe_defs.svh"

module lockstep_delay_line
  import safe_bus_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    shift_i,
  input  logic    lead_req_i,
  input  bus_op_e lead_op_i,
  input  addr_t   lead_addr_i,
  input  data_t   lead_wdata_i,
  input  logic    lead_gnt_i,
  input  logic    lead_rvalid_i,
  input  data_t   lead_rdata_i,
  output logic    dly_req_o,
  output bus_op_e dly_op_o,
  output addr_t   dly_addr_o,
  output data_t   dly_wdata_o,
  output logic    dly_gnt_o,
  output logic    dly_rvalid_o,
  output data_t   dly_rdata_o
);

  localparam int unsigned DEPTH = `SAFE_LOCKSTEP_DELAY;

  // Request stages
  logic  [DEPTH-1:0] req_q;
  logic  [DEPTH-1:0] op_q;
  addr_t [DEPTH-1:0] addr_q;
  data_t [DEPTH-1:0] wdata_q;
  // Response stages
  logic  [DEPTH-1:0] gnt_q;
  logic  [DEPTH-1:0] rvalid_q;
  data_t [DEPTH-1:0] rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q    <= '0;
      op_q     <= '0;
      addr_q   <= '0;
      wdata_q  <= '0;
      gnt_q    <= '0;
      rvalid_q <= '0;
      rdata_q  <= '0;
    end else if (shift_i) begin
      req_q[0]    <= lead_req_i;
      op_q[0]     <= lead_op_i;
      addr_q[0]   <= lead_addr_i;
      wdata_q[0]  <= lead_wdata_i;
      gnt_q[0]    <= lead_gnt_i;
      rvalid_q[0] <= lead_rvalid_i;
      rdata_q[0]  <= lead_rdata_i;
      for (int i = 1; i < DEPTH; i++) begin
        req_q[i]    <= req_q[i-1];
        op_q[i]     <= op_q[i-1];
        addr_q[i]   <= addr_q[i-1];
        wdata_q[i]  <= wdata_q[i-1];
        gnt_q[i]    <= gnt_q[i-1];
        rvalid_q[i] <= rvalid_q[i-1];
        rdata_q[i]  <= rdata_q[i-1];
      end
    end
  end

  assign dly_req_o    = req_q[DEPTH-1];
  assign dly_op_o     = bus_op_e'(op_q[DEPTH-1]);
  assign dly_addr_o   = addr_q[DEPTH-1];
  assign dly_wdata_o  = wdata_q[DEPTH-1];
  assign dly_gnt_o    = gnt_q[DEPTH-1];
  assign dly_rvalid_o = rvalid_q[DEPTH-1];
  assign dly_rdata_o  = rdata_q[DEPTH-1];

endmodule

// File: verilog/redundancy_checker.sv
// TMR majority vote with mismatch flag, and DMR partner-versus-delayed-master compare.
// All request fields are compared, including address and data while req is low.
`timescale 1ns/1ps
`include "safe_defs.svh"

module redundancy_checker
  import safe_mode_pkg::*;
  import safe_bus_pkg::*;
(
  input  fabric_mode_e                     mode_i,
  input  logic                             fill_done_i,
  input  logic    [`SAFE_NHARTS-1:0]       core_req_i,
  input  bus_op_e [`SAFE_NHARTS-1:0]       core_op_i,
  input  addr_t   [`SAFE_NHARTS-1:0]       core_addr_i,
  input  data_t   [`SAFE_NHARTS-1:0]       core_wdata_i,
  input  hart_idx_t                        partner_i,
  input  logic                             dly_req_i,
  input  bus_op_e                          dly_op_i,
  input  addr_t                            dly_addr_i,
  input  data_t                            dly_wdata_i,
  output logic                             vote_req_o,
  output bus_op_e                          vote_op_o,
  output addr_t                            vote_addr_o,
  output data_t                            vote_wdata_o,
  output logic                             tmr_error_o,
  output logic                             dmr_error_o
);

  localparam int unsigned REQ_W = 2 + `SAFE_ADDR_W + `SAFE_DATA_W;

  logic [`SAFE_NHARTS-1:0][REQ_W-1:0] req_word;
  logic [REQ_W-1:0]                   dly_word;
  logic                               tmr_mismatch;
  logic                               dmr_mismatch;

  // Flatten each hart's request for whole-word compare
  for (genvar i = 0; i < `SAFE_NHARTS; i++) begin : gen_word
    assign req_word[i] = {core_req_i[i], core_op_i[i], core_addr_i[i], core_wdata_i[i]};
  end
  assign dly_word = {dly_req_i, dly_op_i, dly_addr_i, dly_wdata_i};

  // Bitwise 2-of-3 per field
  assign vote_req_o   = (core_req_i[0] & core_req_i[1]) | (core_req_i[0] & core_req_i[2])
                      | (core_req_i[1] & core_req_i[2]);
  assign vote_op_o    = bus_op_e'((core_op_i[0] & core_op_i[1]) | (core_op_i[0] & core_op_i[2])
                      | (core_op_i[1] & core_op_i[2]));
  assign vote_addr_o  = (core_addr_i[0] & core_addr_i[1]) | (core_addr_i[0] & core_addr_i[2])
                      | (core_addr_i[1] & core_addr_i[2]);
  assign vote_wdata_o = (core_wdata_i[0] & core_wdata_i[1]) | (core_wdata_i[0] & core_wdata_i[2])
                      | (core_wdata_i[1] & core_wdata_i[2]);

  assign tmr_mismatch = (req_word[0] != req_word[1]) || (req_word[1] != req_word[2]);
  assign tmr_error_o  = (mode_i == MODE_TMR) && tmr_mismatch;

  // Partner must replay what the master issued SAFE_LOCKSTEP_DELAY cycles ago
  assign dmr_mismatch = (req_word[partner_i] != dly_word);
  assign dmr_error_o  = (mode_i == MODE_DMR) && fill_done_i && dmr_mismatch;

endmodule

// File: verilog/hart_bus_router.sv
// Steers hart buses onto memory ports by mode; unused ports keep req low.
// In DMR the partner is master+1 and the parked hart master+2, both modulo 3.
// The parked responder drops pending rvalids when the mode changes.
`timescale 1ns/1ps
`include "safe_defs.svh"

module hart_bus_router
  import safe_mode_pkg::*;
  import safe_bus_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  fabric_mode_e                 mode_i,
  input  hart_idx_t                    master_i,
  input  logic    [`SAFE_NHARTS-1:0]   core_req_i,
  input  bus_op_e [`SAFE_NHARTS-1:0]   core_op_i,
  input  addr_t   [`SAFE_NHARTS-1:0]   core_addr_i,
  input  data_t   [`SAFE_NHARTS-1:0]   core_wdata_i,
  output logic    [`SAFE_NHARTS-1:0]   core_gnt_o,
  output logic    [`SAFE_NHARTS-1:0]   core_rvalid_o,
  output data_t   [`SAFE_NHARTS-1:0]   core_rdata_o,
  output logic    [`SAFE_NHARTS-1:0]   mem_req_o,
  output bus_op_e [`SAFE_NHARTS-1:0]   mem_op_o,
  output addr_t   [`SAFE_NHARTS-1:0]   mem_addr_o,
  output data_t   [`SAFE_NHARTS-1:0]   mem_wdata_o,
  input  logic    [`SAFE_NHARTS-1:0]   mem_gnt_i,
  input  logic    [`SAFE_NHARTS-1:0]   mem_rvalid_i,
  input  data_t   [`SAFE_NHARTS-1:0]   mem_rdata_i,
  input  logic                         vote_req_i,
  input  bus_op_e                      vote_op_i,
  input  addr_t                        vote_addr_i,
  input  data_t                        vote_wdata_i,
  input  logic                         dly_gnt_i,
  input  logic                         dly_rvalid_i,
  input  data_t                        dly_rdata_i,
  output hart_idx_t                    partner_o
);

  hart_idx_t partner;
  hart_idx_t parked;
  logic      park_rvalid_q;

  assign partner = (master_i == hart_idx_t'(`SAFE_NHARTS - 1)) ? '0
                                                               : master_i + hart_idx_t'(1);
  assign parked  = (master_i == '0) ? hart_idx_t'(`SAFE_NHARTS - 1)
                                    : master_i - hart_idx_t'(1);
  assign partner_o = partner;

  // Parked hart: every request granted at once, rvalid next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      park_rvalid_q <= 1'b0;
    end else begin
      park_rvalid_q <= (mode_i == MODE_DMR) && core_req_i[parked];
    end
  end

  always_comb begin
    for (int i = 0; i < `SAFE_NHARTS; i++) begin
      mem_req_o[i]     = 1'b0;
      mem_op_o[i]      = OP_READ;
      mem_addr_o[i]    = '0;
      mem_wdata_o[i]   = '0;
      core_gnt_o[i]    = mem_gnt_i[i];
      core_rvalid_o[i] = mem_rvalid_i[i];
      core_rdata_o[i]  = mem_rdata_i[i];
    end
    case (mode_i)
      MODE_TMR: begin
        mem_req_o[master_i]   = vote_req_i;
        mem_op_o[master_i]    = vote_op_i;
        mem_addr_o[master_i]  = vote_addr_i;
        mem_wdata_o[master_i] = vote_wdata_i;
        // All three harts see the master port's response
        for (int i = 0; i < `SAFE_NHARTS; i++) begin
          core_gnt_o[i]    = mem_gnt_i[master_i];
          core_rvalid_o[i] = mem_rvalid_i[master_i];
          core_rdata_o[i]  = mem_rdata_i[master_i];
        end
      end
      MODE_DMR: begin
        mem_req_o[master_i]   = core_req_i[master_i];
        mem_op_o[master_i]    = core_op_i[master_i];
        mem_addr_o[master_i]  = core_addr_i[master_i];
        mem_wdata_o[master_i] = core_wdata_i[master_i];
        // Partner trails the master through the delay line
        core_gnt_o[partner]    = dly_gnt_i;
        core_rvalid_o[partner] = dly_rvalid_i;
        core_rdata_o[partner]  = dly_rdata_i;
        core_gnt_o[parked]     = core_req_i[parked];
        core_rvalid_o[parked]  = park_rvalid_q;
        core_rdata_o[parked]   = `SAFE_WFI_INSN;
      end
      default: begin
        // Independent harts, one port each
        for (int i = 0; i < `SAFE_NHARTS; i++) begin
          mem_req_o[i]   = core_req_i[i];
          mem_op_o[i]    = core_op_i[i];
          mem_addr_o[i]  = core_addr_i[i];
          mem_wdata_o[i] = core_wdata_i[i];
        end
      end
    endcase
  end

endmodule

// File: verilog/safe_bus_fabric.sv
// Bus fabric for three harts in independent, TMR or delayed DMR operation.
// Mode and master change only while all harts sleep, one cycle after the request.
`timescale 1ns/1ps
`include "safe_defs.svh"

module safe_bus_fabric
  import safe_mode_pkg::*;
  import safe_bus_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic    [`SAFE_NHARTS-1:0] core_req_i,
  input  bus_op_e [`SAFE_NHARTS-1:0] core_op_i,
  input  addr_t   [`SAFE_NHARTS-1:0] core_addr_i,
  input  data_t   [`SAFE_NHARTS-1:0] core_wdata_i,
  output logic    [`SAFE_NHARTS-1:0] core_gnt_o,
  output logic    [`SAFE_NHARTS-1:0] core_rvalid_o,
  output data_t   [`SAFE_NHARTS-1:0] core_rdata_o,
  output logic    [`SAFE_NHARTS-1:0] mem_req_o,
  output bus_op_e [`SAFE_NHARTS-1:0] mem_op_o,
  output addr_t   [`SAFE_NHARTS-1:0] mem_addr_o,
  output data_t   [`SAFE_NHARTS-1:0] mem_wdata_o,
  input  logic    [`SAFE_NHARTS-1:0] mem_gnt_i,
  input  logic    [`SAFE_NHARTS-1:0] mem_rvalid_i,
  input  data_t   [`SAFE_NHARTS-1:0] mem_rdata_i,
  input  fabric_mode_e               mode_req_i,
  input  hart_idx_t                  master_req_i,
  input  logic    [`SAFE_NHARTS-1:0] sleep_i,
  output fabric_mode_e               mode_o,
  output hart_idx_t                  master_o,
  output logic                       tmr_error_o,
  output logic                       dmr_error_o
);

  fabric_mode_e mode_s;
  hart_idx_t    master_s;
  hart_idx_t    partner_s;
  logic         fill_done_s;
  logic         vote_req_s;
  bus_op_e      vote_op_s;
  addr_t        vote_addr_s;
  data_t        vote_wdata_s;
  logic         dly_req_s;
  bus_op_e      dly_op_s;
  addr_t        dly_addr_s;
  data_t        dly_wdata_s;
  logic         dly_gnt_s;
  logic         dly_rvalid_s;
  data_t        dly_rdata_s;

  safe_mode_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .mode_req_i,
    .master_req_i,
    .sleep_i,
    .mode_o   (mode_s),
    .master_o (master_s)
  );

  lockstep_fill_counter u_fill (
    .clk_i,
    .rst_ni,
    .mode_i      (mode_s),
    .fill_done_o (fill_done_s)
  );

  // Master's own bus feeds the delay line
  lockstep_delay_line u_delay (
    .clk_i,
    .rst_ni,
    .shift_i       (mode_s == MODE_DMR),
    .lead_req_i    (core_req_i[master_s]),
    .lead_op_i     (core_op_i[master_s]),
    .lead_addr_i   (core_addr_i[master_s]),
    .lead_wdata_i  (core_wdata_i[master_s]),
    .lead_gnt_i    (mem_gnt_i[master_s]),
    .lead_rvalid_i (mem_rvalid_i[master_s]),
    .lead_rdata_i  (mem_rdata_i[master_s]),
    .dly_req_o     (dly_req_s),
    .dly_op_o      (dly_op_s),
    .dly_addr_o    (dly_addr_s),
    .dly_wdata_o   (dly_wdata_s),
    .dly_gnt_o     (dly_gnt_s),
    .dly_rvalid_o  (dly_rvalid_s),
    .dly_rdata_o   (dly_rdata_s)
  );

  redundancy_checker u_check (
    .mode_i       (mode_s),
    .fill_done_i  (fill_done_s),
    .core_req_i,
    .core_op_i,
    .core_addr_i,
    .core_wdata_i,
    .partner_i    (partner_s),
    .dly_req_i    (dly_req_s),
    .dly_op_i     (dly_op_s),
    .dly_addr_i   (dly_addr_s),
    .dly_wdata_i  (dly_wdata_s),
    .vote_req_o   (vote_req_s),
    .vote_op_o    (vote_op_s),
    .vote_addr_o  (vote_addr_s),
    .vote_wdata_o (vote_wdata_s),
    .tmr_error_o,
    .dmr_error_o
  );

  hart_bus_router u_router (
    .clk_i,
    .rst_ni,
    .mode_i        (mode_s),
    .master_i      (master_s),
    .core_req_i,
    .core_op_i,
    .core_addr_i,
    .core_wdata_i,
    .core_gnt_o,
    .core_rvalid_o,
    .core_rdata_o,
    .mem_req_o,
    .mem_op_o,
    .mem_addr_o,
    .mem_wdata_o,
    .mem_gnt_i,
    .mem_rvalid_i,
    .mem_rdata_i,
    .vote_req_i    (vote_req_s),
    .vote_op_i     (vote_op_s),
    .vote_addr_i   (vote_addr_s),
    .vote_wdata_i  (vote_wdata_s),
    .dly_gnt_i     (dly_gnt_s),
    .dly_rvalid_i  (dly_rvalid_s),
    .dly_rdata_i   (dly_rdata_s),
    .partner_o     (partner_s)
  );

  assign mode_o   = mode_s;
  assign master_o = master_s;

endmodule

// File: tb/tb_safe_bus_fabric.sv
// Seeded random testbench for the three-hart bus fabric.
// A cycle model predicts every DUT output each cycle. Memory gives random gnt and
// returns rvalid one cycle after each accepted request.
`timescale 1ns/1ps
`include "safe_defs.svh"

module tb_safe_bus_fabric
  import safe_mode_pkg::*;
  import safe_bus_pkg::*;
();

  localparam int NH = `SAFE_NHARTS;
  localparam int D  = `SAFE_LOCKSTEP_DELAY;
  localparam int AW = `SAFE_ADDR_W;
  localparam int DW = `SAFE_DATA_W;
  localparam int RW = 2 + AW + DW;

  // Test lengths in cycles
  localparam int T_MODE  = 120;
  localparam int T_INDEP = 60;
  localparam int T_TMR   = 80;
  localparam int T_DMR   = 80;
  localparam int T_PARK  = 40;
  // Margin covers reset and the mode entry cycles
  localparam int MAX_CYCLES = T_MODE + T_INDEP + T_TMR + 2 * T_DMR + 3 * T_PARK + 50;

  logic             clk_i;
  logic             rst_ni;
  logic    [NH-1:0] core_req_i;
  bus_op_e [NH-1:0] core_op_i;
  addr_t   [NH-1:0] core_addr_i;
  data_t   [NH-1:0] core_wdata_i;
  logic    [NH-1:0] core_gnt_o;
  logic    [NH-1:0] core_rvalid_o;
  data_t   [NH-1:0] core_rdata_o;
  logic    [NH-1:0] mem_req_o;
  bus_op_e [NH-1:0] mem_op_o;
  addr_t   [NH-1:0] mem_addr_o;
  data_t   [NH-1:0] mem_wdata_o;
  logic    [NH-1:0] mem_gnt_i;
  logic    [NH-1:0] mem_rvalid_i;
  data_t   [NH-1:0] mem_rdata_i;
  fabric_mode_e     mode_req_i;
  hart_idx_t        master_req_i;
  logic    [NH-1:0] sleep_i;
  fabric_mode_e     mode_o;
  hart_idx_t        master_o;
  logic             tmr_error_o;
  logic             dmr_error_o;

  // Stimulus applied at the next rising edge
  logic    [NH-1:0] s_req;
  bus_op_e [NH-1:0] s_op;
  addr_t   [NH-1:0] s_addr;
  data_t   [NH-1:0] s_wdata;
  fabric_mode_e     s_mode;
  hart_idx_t        s_master;
  logic    [NH-1:0] s_sleep;

  // Reference model state
  fabric_mode_e  exp_mode;
  hart_idx_t     exp_master;
  int            fill;
  logic          park_q;
  logic [NH-1:0] pend;
  logic [RW-1:0] h_req [D];
  logic          h_gnt [D];
  logic          h_rv  [D];
  data_t         h_rd  [D];

  int n_checks  = 0;
  int n_errors  = 0;
  int err_mark  = 0;
  int cycle_cnt = 0;

  safe_bus_fabric u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic check_mode(input fabric_mode_e got, input fabric_mode_e exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %0s expected %0s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_hart(input hart_idx_t got, input hart_idx_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_op(input bus_op_e got, input bus_op_e exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %0s expected %0s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // Compares all outputs with the model, then advances the model by one edge
  task automatic evaluate();
    hart_idx_t     ms;
    hart_idx_t     pt;
    hart_idx_t     pk;
    logic [RW-1:0] rq    [NH];
    logic [RW-1:0] e_mem [NH];
    logic          e_gnt;
    logic          e_rv;
    data_t         e_rd;
    int            src;
    ms = exp_master;
    pt = hart_idx_t'((int'(ms) + 1) % NH);
    pk = hart_idx_t'((int'(ms) + 2) % NH);
    check_mode(mode_o, exp_mode, "mode_o");
    check_hart(master_o, exp_master, "master_o");
    for (int i = 0; i < NH; i++) begin
      rq[i]    = {core_req_i[i], core_op_i[i], core_addr_i[i], core_wdata_i[i]};
      e_mem[i] = '0;
    end
    if (exp_mode == MODE_INDEP) begin
      for (int i = 0; i < NH; i++) begin
        e_mem[i] = rq[i];
      end
    end else if (exp_mode == MODE_TMR) begin
      // Each bit takes the value held by at least two harts
      for (int b = 0; b < RW; b++) begin
        e_mem[ms][b] = (int'(rq[0][b]) + int'(rq[1][b]) + int'(rq[2][b])) >= 2;
      end
    end else begin
      e_mem[ms] = rq[ms];
    end
    for (int i = 0; i < NH; i++) begin
      check_flag(mem_req_o[i], e_mem[i][RW-1], $sformatf("mem_req[%0d]", i));
      if (e_mem[i][RW-1]) begin
        check_op(mem_op_o[i], bus_op_e'(e_mem[i][RW-2]), $sformatf("mem_op[%0d]", i));
        check_addr(mem_addr_o[i], e_mem[i][AW+DW-1:DW], $sformatf("mem_addr[%0d]", i));
        check_data(mem_wdata_o[i], e_mem[i][DW-1:0], $sformatf("mem_wdata[%0d]", i));
      end
      src   = (exp_mode == MODE_TMR) ? int'(ms) : i;
      e_gnt = mem_gnt_i[src];
      e_rv  = mem_rvalid_i[src];
      e_rd  = mem_rdata_i[src];
      if (exp_mode == MODE_DMR && i == int'(pt)) begin
        e_gnt = h_gnt[D-1];
        e_rv  = h_rv[D-1];
        e_rd  = h_rd[D-1];
      end
      if (exp_mode == MODE_DMR && i == int'(pk)) begin
        e_gnt = core_req_i[pk];
        e_rv  = park_q;
        e_rd  = `SAFE_WFI_INSN;
      end
      check_flag(core_gnt_o[i], e_gnt, $sformatf("core_gnt[%0d]", i));
      check_flag(core_rvalid_o[i], e_rv, $sformatf("core_rvalid[%0d]", i));
      check_data(core_rdata_o[i], e_rd, $sformatf("core_rdata[%0d]", i));
    end
    check_flag(tmr_error_o, exp_mode == MODE_TMR && (rq[0] != rq[1] || rq[1] != rq[2]),
               "tmr_error_o");
    check_flag(dmr_error_o, exp_mode == MODE_DMR && fill == D && rq[pt] != h_req[D-1],
               "dmr_error_o");
    // Next state
    for (int i = 0; i < NH; i++) begin
      pend[i] = e_mem[i][RW-1] & mem_gnt_i[i];
    end
    park_q = (exp_mode == MODE_DMR) && core_req_i[pk];
    if (exp_mode == MODE_DMR) begin
      for (int k = D - 1; k > 0; k--) begin
        h_req[k] = h_req[k-1];
        h_gnt[k] = h_gnt[k-1];
        h_rv[k]  = h_rv[k-1];
        h_rd[k]  = h_rd[k-1];
      end
      h_req[0] = rq[ms];
      h_gnt[0] = mem_gnt_i[ms];
      h_rv[0]  = mem_rvalid_i[ms];
      h_rd[0]  = mem_rdata_i[ms];
      if (fill < D) begin
        fill++;
      end
    end else begin
      fill = 0;
    end
    if (&sleep_i) begin
      exp_mode   = mode_req_i;
      exp_master = master_req_i;
    end
  endtask

  // Drive on the rising edge, check at the falling edge
  task automatic tick();
    data_t [NH-1:0] rd;
    for (int i = 0; i < NH; i++) begin
      rd[i] = $urandom;
    end
    @(posedge clk_i);
    core_req_i   <= s_req;
    core_op_i    <= s_op;
    core_addr_i  <= s_addr;
    core_wdata_i <= s_wdata;
    mode_req_i   <= s_mode;
    master_req_i <= s_master;
    sleep_i      <= s_sleep;
    mem_gnt_i    <= NH'($urandom);
    mem_rvalid_i <= pend;
    mem_rdata_i  <= rd;
    @(negedge clk_i);
    evaluate();
  endtask

  task automatic random_traffic();
    s_req = NH'($urandom);
    for (int i = 0; i < NH; i++) begin
      s_op[i]    = bus_op_e'(1'($urandom));
      s_addr[i]  = $urandom;
      s_wdata[i] = $urandom;
    end
  endtask

  task automatic enter_mode(input fabric_mode_e m, input hart_idx_t ms);
    s_req    = '0;
    s_mode   = m;
    s_master = ms;
    s_sleep  = '1;
    tick();
    s_sleep  = '0;
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d errors", name, n_errors - err_mark);
    err_mark = n_errors;
  endtask

  task automatic run_mode_test();
    for (int k = 0; k < T_MODE; k++) begin
      random_traffic();
      s_mode   = fabric_mode_e'($urandom_range(2, 0));
      s_master = hart_idx_t'($urandom_range(NH - 1, 0));
      s_sleep  = ($urandom_range(3, 0) == 0) ? '1 : NH'($urandom);
      tick();
    end
  endtask

  task automatic run_tmr_test();
    int h;
    enter_mode(MODE_TMR, hart_idx_t'($urandom_range(NH - 1, 0)));
    for (int k = 0; k < T_TMR; k++) begin
      random_traffic();
      s_req = {NH{s_req[0]}};
      s_op  = {NH{s_op[0]}};
      for (int i = 1; i < NH; i++) begin
        s_addr[i]  = s_addr[0];
        s_wdata[i] = s_wdata[0];
      end
      // One hart out of three corrupted in two thirds of the cycles
      h = $urandom_range(NH - 1, 0);
      case ($urandom_range(2, 0))
        0: s_addr[h] ^= addr_t'(1) << $urandom_range(AW - 1, 0);
        1: s_wdata[h] ^= data_t'(1) << $urandom_range(DW - 1, 0);
        default: ;
      endcase
      tick();
    end
  endtask

  // Partner replays the master at the lockstep distance, optionally with faults
  task automatic run_lockstep(input hart_idx_t ms, input int len, input bit inject);
    logic [RW-1:0] hist [$];
    logic [RW-1:0] pw;
    logic          prev_pk;
    hart_idx_t     pt;
    hart_idx_t     pk;
    pt      = hart_idx_t'((int'(ms) + 1) % NH);
    pk      = hart_idx_t'((int'(ms) + 2) % NH);
    prev_pk = 1'b0;
    enter_mode(MODE_INDEP, ms);
    enter_mode(MODE_DMR, ms);
    for (int k = 0; k < len; k++) begin
      random_traffic();
      hist.push_back({s_req[ms], s_op[ms], s_addr[ms], s_wdata[ms]});
      pw = (hist.size() > D) ? hist[hist.size() - 1 - D] : '0;
      if (inject && (k < D || $urandom_range(3, 0) == 0)) begin
        pw[0] = ~pw[0];
      end
      s_req[pt]   = pw[RW-1];
      s_op[pt]    = bus_op_e'(pw[RW-2]);
      s_addr[pt]  = pw[AW+DW-1:DW];
      s_wdata[pt] = pw[DW-1:0];
      tick();
      if (k < D || !inject) begin
        check_flag(dmr_error_o, 1'b0, "dmr_error_o without valid fault");
      end
      check_flag(mem_req_o[pk], 1'b0, "parked request on memory");
      check_flag(core_gnt_o[pk], s_req[pk], "parked gnt");
      check_flag(core_rvalid_o[pk], prev_pk, "parked rvalid");
      check_data(core_rdata_o[pk], `SAFE_WFI_INSN, "parked rdata");
      prev_pk = s_req[pk];
    end
  endtask

  initial begin
    void'($urandom(32'hcd15));
    rst_ni       = 1'b0;
    core_req_i   = '0;
    core_op_i    = {NH{OP_READ}};
    core_addr_i  = '0;
    core_wdata_i = '0;
    mem_gnt_i    = '0;
    mem_rvalid_i = '0;
    mem_rdata_i  = '0;
    mode_req_i   = MODE_INDEP;
    master_req_i = '0;
    sleep_i      = '0;
    s_req        = '0;
    s_op         = {NH{OP_READ}};
    s_addr       = '0;
    s_wdata      = '0;
    s_mode       = MODE_INDEP;
    s_master     = '0;
    s_sleep      = '0;
    exp_mode     = MODE_INDEP;
    exp_master   = '0;
    fill         = 0;
    park_q       = 1'b0;
    pend         = '0;
    for (int k = 0; k < D; k++) begin
      h_req[k] = '0;
      h_gnt[k] = 1'b0;
      h_rv[k]  = 1'b0;
      h_rd[k]  = '0;
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    evaluate();
    run_mode_test();
    report_test("mode and master commit");
    enter_mode(MODE_INDEP, hart_idx_t'($urandom_range(NH - 1, 0)));
    for (int k = 0; k < T_INDEP; k++) begin
      random_traffic();
      tick();
    end
    report_test("independent traffic");
    run_tmr_test();
    report_test("tmr vote and error");
    run_lockstep(hart_idx_t'($urandom_range(NH - 1, 0)), T_DMR, 1'b0);
    report_test("dmr replay");
    run_lockstep(hart_idx_t'($urandom_range(NH - 1, 0)), T_DMR, 1'b1);
    report_test("dmr fault injection");
    for (int m = 0; m < NH; m++) begin
      run_lockstep(hart_idx_t'(m), T_PARK, 1'b0);
    end
    report_test("dmr parked hart");
    $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: safe_bus_fabric.f
+incdir+common
common/safe_mode_pkg.sv
common/safe_bus_pkg.sv
verilog/safe_mode_fsm.sv
lockstep/lockstep_fill_counter.sv
lockstep/lockstep_delay_line.sv
verilog/redundancy_checker.sv
verilog/hart_bus_router.sv
verilog/safe_bus_fabric.sv
tb/tb_safe_bus_fabric.sv

// File: Makefile
SIM      ?= verilator
TOP      ?= tb_safe_bus_fabric
FILELIST ?= safe_bus_fabric.f
FLAGS    ?= --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
